// ==== hdl/opl_phase_pkg.sv ====
package opl_phase_pkg;

    // bank geometry
    localparam int NUM_SLOTS       = 18;
    localparam int SLOT_WIDTH      = 5;
    localparam int PHASE_ACC_WIDTH = 10; // phase handed to the waveform stage
    localparam int ACC_WIDTH       = 19; // phase is the top PHASE_ACC_WIDTH bits
    localparam int INC_WIDTH       = 17;

    // rhythm slot map, only meaningful while rhythm mode is on
    localparam logic [SLOT_WIDTH-1:0] SLOT_BASS_DRUM   = 5'd12;
    localparam logic [SLOT_WIDTH-1:0] SLOT_HI_HAT      = 5'd13;
    localparam logic [SLOT_WIDTH-1:0] SLOT_TOM_TOM     = 5'd14;
    localparam logic [SLOT_WIDTH-1:0] SLOT_BASS_DRUM2  = 5'd15; // second half of the bass drum pair
    localparam logic [SLOT_WIDTH-1:0] SLOT_SNARE_DRUM  = 5'd16;
    localparam logic [SLOT_WIDTH-1:0] SLOT_TOP_CYMBAL  = 5'd17;
    localparam logic [SLOT_WIDTH-1:0] SLOT_NOISE_TICK  = 5'd0;  // step here = new sample

    // galois lfsr for percussion noise
    localparam int                    RAND_NUM_WIDTH  = 23;
    localparam logic [RAND_NUM_WIDTH-1:0] RAND_POLYNOMIAL = 23'h800302;

    typedef enum logic [1:0] {
        OPC_KEY_ON = 2'd0, // clear accumulator, return 0
        OPC_STEP   = 2'd1, // add increment, return new phase
        OPC_READ   = 2'd2  // return current phase, no update
    } opcode_t;

    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } operator_t;

    // host command, 25 bits
    typedef struct packed {
        opcode_t                opcode;
        logic [SLOT_WIDTH-1:0]  slot;
        logic                   rhythm_en;
        logic [INC_WIDTH-1:0]   phase_inc;
    } phase_cmd_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [SLOT_WIDTH-1:0]  slot;
        operator_t              op_type;
        logic [INC_WIDTH-1:0]   phase_inc;
        logic                   noise_tick; // step on slot 0
    } decoded_cmd_t;

    typedef struct packed {
        logic [SLOT_WIDTH-1:0]      slot;
        operator_t                  op_type;
        logic                       noise_tick;
        logic                       advance;    // accumulator was stepped
        logic [PHASE_ACC_WIDTH-1:0] phase;
    } raw_phase_t;

endpackage

// ==== hdl/op_decode.sv ====
`timescale 1ns/1ns

module op_decode
    import opl_phase_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  phase_cmd_t   cmd,
    input  logic         req,
    input  logic         busy,
    output decoded_cmd_t dec,
    output logic         dec_valid
);

    logic      req_q;    // req as seen on the previous edge
    logic      accept;
    operator_t op_type_d;

    // new command only on a fresh req edge and with the result side idle
    assign accept = req && !req_q && !busy;

    // slot to percussion voice, only with rhythm on
    always_comb begin
        op_type_d = OP_NORMAL;
        if (cmd.rhythm_en && cmd.opcode != OPC_KEY_ON) begin // key-on never transforms
            case (cmd.slot)
                SLOT_BASS_DRUM:  op_type_d = OP_BASS_DRUM;
                SLOT_BASS_DRUM2: op_type_d = OP_BASS_DRUM;
                SLOT_HI_HAT:     op_type_d = OP_HI_HAT;
                SLOT_TOM_TOM:    op_type_d = OP_TOM_TOM;
                SLOT_SNARE_DRUM: op_type_d = OP_SNARE_DRUM;
                SLOT_TOP_CYMBAL: op_type_d = OP_TOP_CYMBAL;
                default:         op_type_d = OP_NORMAL;
            endcase
        end
    end

    // handshake control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            req_q     <= req;
            dec_valid <= accept; // single cycle pulse
        end
    end

    // command fields, only loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dec.opcode     <= cmd.opcode;
            dec.slot       <= cmd.slot;
            dec.op_type    <= op_type_d;
            dec.phase_inc  <= cmd.phase_inc;
            dec.noise_tick <= (cmd.opcode == OPC_STEP) && (cmd.slot == SLOT_NOISE_TICK);
        end
    end

endmodule

// ==== hdl/phase_accum.sv ====
`timescale 1ns/1ns

module phase_accum
    import opl_phase_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  decoded_cmd_t dec,
    input  logic         dec_valid,
    output raw_phase_t   raw,
    output logic         raw_valid
);

    logic [ACC_WIDTH-1:0] acc [NUM_SLOTS]; // one accumulator per operator slot
    logic [ACC_WIDTH-1:0] acc_cur;
    logic [ACC_WIDTH-1:0] acc_nxt;
    logic                 slot_ok;

    // slots 18..31 do not exist, they read as zero and are never written
    assign slot_ok = (dec.slot < NUM_SLOTS);

    always_comb begin
        acc_cur = '0;
        if (slot_ok)
            acc_cur = acc[dec.slot];

        case (dec.opcode)
            OPC_KEY_ON: acc_nxt = '0;
            // wraps modulo 2^19 by width
            OPC_STEP:   acc_nxt = acc_cur + {{(ACC_WIDTH-INC_WIDTH){1'b0}}, dec.phase_inc};
            default:    acc_nxt = acc_cur; // read
        endcase
    end

    // accumulator array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++)
                acc[i] <= '0;
        end else if (dec_valid && slot_ok) begin
            acc[dec.slot] <= acc_nxt; // read writes back the same value
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            raw_valid <= 1'b0;
        else
            raw_valid <= dec_valid;
    end

    // result fields for the rhythm stage
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            raw.slot       <= dec.slot;
            raw.op_type    <= dec.op_type;
            raw.noise_tick <= dec.noise_tick;
            raw.advance    <= (dec.opcode == OPC_STEP);
            raw.phase      <= acc_nxt[ACC_WIDTH-1 -: PHASE_ACC_WIDTH]; // top bits
        end
    end

endmodule

// ==== hdl/calc_rhythm_phase.sv ====
`timescale 1ns/1ns

module calc_rhythm_phase
    import opl_phase_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  raw_phase_t                 raw,
    input  logic                       raw_valid,
    output logic [PHASE_ACC_WIDTH-1:0] rhythm_phase,
    output logic                       rhythm_valid
);

    logic [PHASE_ACC_WIDTH-1:0] hh_phase;   // last hi-hat phase, shared with snare and cymbal
    logic [RAND_NUM_WIDTH-1:0]  rand_num;   // noise lfsr
    logic [PHASE_ACC_WIDTH-1:0] sel_phase;
    logic                       phase_bit;
    logic                       noise_bit;
    logic [PHASE_ACC_WIDTH-1:0] phase_d;
    logic                       hh_capture;

    // hi hat stepped in rhythm mode
    assign hh_capture = raw_valid && raw.advance &&
                        (raw.op_type == OP_HI_HAT) && (raw.slot == SLOT_HI_HAT);

    always_comb begin
        // cymbal works off the hi-hat phase, hi hat off its own
        sel_phase = (raw.op_type == OP_TOP_CYMBAL) ? hh_phase : raw.phase;

        phase_bit = (sel_phase[7] ^ sel_phase[2]) | sel_phase[3] |
                    (sel_phase[5] ^ sel_phase[3]);
        noise_bit = rand_num[0]; // value before this command's tick

        case (raw.op_type)
            OP_HI_HAT: begin
                phase_d = {phase_bit, 9'd0} | (10'h034 << (phase_bit ^ noise_bit));
            end
            OP_SNARE_DRUM: begin
                phase_d = hh_phase[8] ? 10'h200 : 10'h100;
                phase_d[8] = phase_d[8] ^ noise_bit;
            end
            OP_TOP_CYMBAL: begin
                phase_d = phase_bit ? 10'h300 : 10'h100;
            end
            default: phase_d = raw.phase; // normal, bass drum, tom tom
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hh_phase     <= '0;
            rand_num     <= RAND_NUM_WIDTH'(1);
            rhythm_valid <= 1'b0;
        end else begin
            rhythm_valid <= raw_valid;
            if (hh_capture)
                hh_phase <= raw.phase;
            // galois shift, once per sample
            if (raw_valid && raw.noise_tick) begin
                if (rand_num[0])
                    rand_num <= (rand_num ^ RAND_POLYNOMIAL) >> 1;
                else
                    rand_num <= rand_num >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid)
            rhythm_phase <= phase_d;
    end

endmodule

// ==== hdl/result_hold.sv ====
`timescale 1ns/1ns

module result_hold
    import opl_phase_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic [PHASE_ACC_WIDTH-1:0] rhythm_phase,
    input  logic                       rhythm_valid,
    output logic [PHASE_ACC_WIDTH-1:0] phase_out,
    output logic                       ack,
    output logic                       busy
);

    // ack side of the four-phase exchange
    // busy covers the whole exchange so decode ignores req until ack is back low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (rhythm_valid)
                ack <= 1'b1;       // result arrived
            else if (!req)
                ack <= 1'b0;       // host released req

            if (req)
                busy <= 1'b1;      // command entered or still held
            else if (ack)
                busy <= 1'b0;      // falls together with ack
        end
    end

    // returned phase, stable for as long as ack is high
    always_ff @(posedge clk) begin
        if (rhythm_valid)
            phase_out <= rhythm_phase;
    end

endmodule

// ==== hdl/opl_phase_top.sv ====
`timescale 1ns/1ns

module opl_phase_top
    import opl_phase_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  phase_cmd_t                 cmd,
    output logic [PHASE_ACC_WIDTH-1:0] phase_out,
    output logic                       ack
);

    decoded_cmd_t               dec;
    logic                       dec_valid;
    raw_phase_t                 raw;
    logic                       raw_valid;
    logic [PHASE_ACC_WIDTH-1:0] rhythm_phase;
    logic                       rhythm_valid;
    logic                       busy;

    // decode, req edge to dec_valid
    op_decode u_op_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .req       (req),
        .busy      (busy),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    phase_accum u_phase_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .dec_valid (dec_valid),
        .raw       (raw),
        .raw_valid (raw_valid)
    );

    calc_rhythm_phase u_calc_rhythm_phase (
        .clk          (clk),
        .rst_n        (rst_n),
        .raw          (raw),
        .raw_valid    (raw_valid),
        .rhythm_phase (rhythm_phase),
        .rhythm_valid (rhythm_valid)
    );

    // result and ack, busy goes back to decode
    result_hold u_result_hold (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .rhythm_phase (rhythm_phase),
        .rhythm_valid (rhythm_valid),
        .phase_out    (phase_out),
        .ack          (ack),
        .busy         (busy)
    );

endmodule

// ==== sim/tb_opl_phase.sv ====
`timescale 1ns/1ns

module tb_opl_phase
    import opl_phase_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int MAX_TESTS  = 64;
    localparam int ACK_EDGES  = 4;  // req sampled high to ack seen

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    phase_cmd_t                 cmd;
    logic [PHASE_ACC_WIDTH-1:0] phase_out;
    logic                       ack;

    string                      test_name [MAX_TESTS];
    phase_cmd_t                 test_cmd  [MAX_TESTS];
    logic [PHASE_ACC_WIDTH-1:0] test_exp  [MAX_TESTS];  // filled by the model below
    int                         n_tests;
    logic                       table_ready;
    logic [ACC_WIDTH-1:0]       m_acc [NUM_SLOTS];      // model accumulators
    logic [PHASE_ACC_WIDTH-1:0] m_hh;                   // model hi-hat capture
    logic [RAND_NUM_WIDTH-1:0]  m_noise;                // model noise register
    logic [31:0]                rng;
    int                         value_errors;
    int                         hs_errors;

    opl_phase_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cmd       (cmd),
        .phase_out (phase_out),
        .ack       (ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic phase_bit_of(input logic [PHASE_ACC_WIDTH-1:0] p);
        return (p[7] ^ p[2]) | p[3] | (p[5] ^ p[3]);
    endfunction

    // append one command and work out its expected phase
    task automatic add_test(input string base, input opcode_t opc, input int slot,
                            input logic rhythm, input logic big_inc);
        logic [INC_WIDTH-1:0]       inc;
        logic [PHASE_ACC_WIDTH-1:0] ph;
        logic [PHASE_ACC_WIDTH-1:0] res;
        logic                       pb;
        logic                       nb;
        rng = xorshift32(rng);
        inc = rng[INC_WIDTH-1:0];
        if (big_inc)
            inc[INC_WIDTH-1] = 1'b1;  // eight of these must wrap 2^19
        if (opc == OPC_KEY_ON)
            m_acc[slot] = '0;
        else if (opc == OPC_STEP)
            m_acc[slot] = m_acc[slot] + ACC_WIDTH'(inc);
        ph  = m_acc[slot][ACC_WIDTH-1 -: PHASE_ACC_WIDTH];
        nb  = m_noise[0];  // noise before this command's tick
        res = ph;
        if (rhythm && opc != OPC_KEY_ON) begin
            if (slot == 13) begin  // hi hat
                pb  = phase_bit_of(ph);
                res = {pb, 9'd0} | ((pb != nb) ? 10'h068 : 10'h034);
                if (opc == OPC_STEP)
                    m_hh = ph;
            end else if (slot == 16) begin  // snare drum
                res    = m_hh[8] ? 10'h200 : 10'h100;
                res[8] = res[8] ^ nb;
            end else if (slot == 17) begin  // top cymbal
                res = phase_bit_of(m_hh) ? 10'h300 : 10'h100;
            end
        end
        if (opc == OPC_STEP && slot == 0)
            m_noise = m_noise[0] ? (m_noise ^ 23'h800302) >> 1 : m_noise >> 1;
        test_name[n_tests]           = $sformatf("%s_s%0d", base, slot);
        test_cmd[n_tests].opcode     = opc;
        test_cmd[n_tests].slot       = slot[SLOT_WIDTH-1:0];
        test_cmd[n_tests].rhythm_en  = rhythm;
        test_cmd[n_tests].phase_inc  = inc;
        test_exp[n_tests]            = res;
        n_tests++;
    endtask

    // full four-phase exchange for one table entry
    task automatic run_exchange(input int idx);
        int                         edges;
        logic [PHASE_ACC_WIDTH-1:0] held;
        @(negedge clk);
        cmd   = test_cmd[idx];
        req   = 1'b1;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && edges < 2*ACK_EDGES);
        if (!ack || edges != ACK_EDGES) begin
            $display("%s: ack seen %0d after %0d edges, wanted 1 after %0d edges",
                     test_name[idx], ack, edges, ACK_EDGES);
            hs_errors++;
        end
        if (phase_out !== test_exp[idx]) begin
            $display("FAIL %s expected %h actual %h", test_name[idx], test_exp[idx], phase_out);
            value_errors++;
        end
        held = phase_out;
        repeat (3) begin  // host keeps req up a while
            @(posedge clk);
            @(negedge clk);
            if (!ack || phase_out !== held) begin
                $display("%s: ack or phase_out moved while req was held", test_name[idx]);
                hs_errors++;
            end
        end
        req = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (ack) begin
            $display("%s: ack still high one edge after req dropped", test_name[idx]);
            hs_errors++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        req          = 1'b0;
        cmd          = '0;
        value_errors = 0;
        hs_errors    = 0;
        n_tests      = 0;
        table_ready  = 1'b0;
        rng          = 32'd27;
        m_hh         = '0;
        m_noise      = RAND_NUM_WIDTH'(1);
        for (int s = 0; s < NUM_SLOTS; s++)
            m_acc[s] = '0;
        for (int s = 0; s < NUM_SLOTS; s++)
            add_test("read_rst", OPC_READ, s, 1'b0, 1'b0);
        add_test("step", OPC_STEP, 1, 1'b0, 1'b0);
        add_test("step", OPC_STEP, 1, 1'b0, 1'b0);
        add_test("read", OPC_READ, 1, 1'b0, 1'b0);
        add_test("key_on", OPC_KEY_ON, 1, 1'b0, 1'b0);
        add_test("restart", OPC_STEP, 1, 1'b0, 1'b0);
        for (int k = 0; k < 8; k++)
            add_test("wrap", OPC_STEP, 2, 1'b0, 1'b1);
        add_test("rhy_off", OPC_STEP, 13, 1'b0, 1'b0);
        add_test("rhy_off", OPC_STEP, 16, 1'b0, 1'b0);
        add_test("rhy_off", OPC_STEP, 17, 1'b0, 1'b0);
        add_test("pass_bd", OPC_STEP, 12, 1'b1, 1'b0);
        add_test("pass_tt", OPC_STEP, 14, 1'b1, 1'b0);
        add_test("pass_bd2", OPC_STEP, 15, 1'b1, 1'b0);
        add_test("sd_early", OPC_STEP, 16, 1'b1, 1'b0);  // before any hi-hat capture
        for (int k = 0; k < 6; k++)
            add_test("pre_tick", OPC_STEP, 0, 1'b0, 1'b0);  // noise bit turns 0 at the 8th tick
        for (int k = 0; k < 2; k++) begin
            add_test("tick", OPC_STEP, 0, 1'b1, 1'b0);
            add_test("hh", OPC_STEP, 13, 1'b1, 1'b0);
            add_test("sd", OPC_STEP, 16, 1'b1, 1'b0);
            add_test("tc", OPC_STEP, 17, 1'b1, 1'b0);
        end
        add_test("hh_read", OPC_READ, 13, 1'b1, 1'b0);
        add_test("hh_key_on", OPC_KEY_ON, 13, 1'b1, 1'b0);
        add_test("hh_restart", OPC_STEP, 13, 1'b1, 1'b0);
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (ack) begin
            $display("ack is high right after reset");
            hs_errors++;
        end
        for (int i = 0; i < n_tests; i++)
            run_exchange(i);
        $display("value errors %0d, handshake errors %0d", value_errors, hs_errors);
        if (value_errors == 0 && hs_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // watchdog allows 12 cycles per exchange plus reset and slack
    initial begin
        wait (table_ready === 1'b1);
        #((n_tests * 12 + 8) * CLK_PERIOD);
        $display("timeout, the exchanges did not complete in the allowed time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/opl_phase_pkg.sv
hdl/op_decode.sv
hdl/phase_accum.sv
hdl/calc_rhythm_phase.sv
hdl/result_hold.sv
hdl/opl_phase_top.sv
sim/tb_opl_phase.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_opl_phase -f project.f \
		-Mdir obj_dir -o sim_opl_phase

run: compile
	./obj_dir/sim_opl_phase > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
